// File: common/audio_pkg.sv
package audio_pkg;

  ////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////

  // upper byte of the codec sample
  typedef logic [7:0] sample_t;

  // 0 is quietest, 31 is loudest
  typedef logic [4:0] volume_t;

  typedef struct packed {
    logic [7:0]  address;
    logic [15:0] data;
  } codec_command_t;

  // one word of a captured block
  typedef struct packed {
    logic    last;
    sample_t sample;
  } block_word_t;

  localparam volume_t VOLUME_RESET = 5'd8;
  localparam volume_t VOLUME_MAX = 5'd31;

  ////////////////////////////////////////////////////////////
  // codec register commands
  ////////////////////////////////////////////////////////////

  localparam codec_command_t CMD_READ_ID = '{address: 8'h80, data: 16'h0000};
  localparam codec_command_t CMD_PCM_VOLUME = '{address: 8'h18, data: 16'h0808};
  // source fixed at mic
  localparam codec_command_t CMD_RECORD_SOURCE = '{address: 8'h1A, data: 16'h0000};
  // record gain at max
  localparam codec_command_t CMD_RECORD_GAIN = '{address: 8'h1C, data: 16'h0F0F};
  // +20 dB mic boost
  localparam codec_command_t CMD_MIC_GAIN = '{address: 8'h0E, data: 16'h8048};
  localparam codec_command_t CMD_BEEP_VOLUME = '{address: 8'h0A, data: 16'h0000};
  localparam codec_command_t CMD_BYPASS_MIX = '{address: 8'h20, data: 16'h8000};

  // data field is built from the volume at run time
  localparam logic [7:0] REG_HEADPHONE_VOLUME = 8'h04;

endpackage

// File: verilog/key_debounce.sv
`timescale 1ns/1ps

module key_debounce #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int COUNT_BITS = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [COUNT_BITS-1:0] COUNT_DONE = COUNT_BITS'(DEBOUNCE_CYCLES);

  logic [COUNT_BITS-1:0] count;
  // last sampled input level
  logic held;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      held <= noisy;
      clean <= noisy;
    end else if (noisy != held) begin
      // input moved, start timing again
      held <= noisy;
      count <= '0;
    end else if (count == COUNT_DONE) begin
      // level has been stable long enough
      clean <= held;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: verilog/volume_control.sv
`timescale 1ns/1ps

module volume_control #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic               clock_27mhz,
  input  logic               reset,
  input  logic               button_up,
  input  logic               button_down,
  output audio_pkg::volume_t volume
);

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_rise;
  logic down_rise;

  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) debounce_up (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(button_up),
    .clean(up_clean)
  );

  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) debounce_down (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(button_down),
    .clean(down_clean)
  );

  assign up_rise = up_clean & ~up_prev;
  assign down_rise = down_clean & ~down_prev;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      volume <= audio_pkg::VOLUME_RESET;
    end else if (up_rise) begin
      // up has priority when both keys rise together
      if (volume != audio_pkg::VOLUME_MAX) begin
        volume <= volume + 1'b1;
      end
    end else if (down_rise) begin
      if (volume != '0) begin
        volume <= volume - 1'b1;
      end
    end
    up_prev <= up_clean;
    down_prev <= down_clean;
  end

  // no wrap in either direction
  assert property (@(posedge clock_27mhz) disable iff (reset)
    (volume == audio_pkg::VOLUME_MAX) |=> (volume != '0));
  assert property (@(posedge clock_27mhz) disable iff (reset)
    (volume == '0) |=> (volume != audio_pkg::VOLUME_MAX));

endmodule

// File: codec/codec_command_sequencer.sv
`timescale 1ns/1ps

module codec_command_sequencer #(
  parameter int CODEC_RESET_CYCLES = 1024
) (
  input  logic                       clock_27mhz,
  input  logic                       reset,
  input  logic                       frame_tick,
  input  audio_pkg::volume_t         volume,
  output logic                       codec_reset_b,
  output audio_pkg::codec_command_t  codec_command,
  output logic                       command_valid
);

  localparam int HOLD_BITS = $clog2(CODEC_RESET_CYCLES + 1);
  localparam logic [HOLD_BITS-1:0] HOLD_LAST = HOLD_BITS'(CODEC_RESET_CYCLES - 1);

  typedef enum logic {
    HOLD,
    RUN
  } state_t;

  state_t state;
  logic [HOLD_BITS-1:0] hold_count;
  logic [3:0] step;
  // codec_command holds a table entry
  logic command_loaded;
  audio_pkg::volume_t attenuation;
  audio_pkg::codec_command_t table_entry;

  assign codec_reset_b = (state == RUN);
  assign attenuation = audio_pkg::VOLUME_MAX - volume;

  ////////////////////////////////////////////////////////////
  // reset hold and frame step counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state <= HOLD;
      hold_count <= '0;
      step <= '0;
    end else begin
      case (state)
        HOLD: begin
          if (hold_count == HOLD_LAST) begin
            state <= RUN;
          end else begin
            hold_count <= hold_count + 1'b1;
          end
        end
        RUN: begin
          // wraps 15 -> 0
          if (frame_tick) begin
            step <= step + 1'b1;
          end
        end
        default: state <= HOLD;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // command table
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (step)
      4'd3: begin
        table_entry.address = audio_pkg::REG_HEADPHONE_VOLUME;
        table_entry.data = {3'b000, attenuation, 3'b000, attenuation};
      end
      4'd5: table_entry = audio_pkg::CMD_PCM_VOLUME;
      4'd6: table_entry = audio_pkg::CMD_RECORD_SOURCE;
      4'd7: table_entry = audio_pkg::CMD_RECORD_GAIN;
      4'd9: table_entry = audio_pkg::CMD_MIC_GAIN;
      4'd10: table_entry = audio_pkg::CMD_BEEP_VOLUME;
      4'd11: table_entry = audio_pkg::CMD_BYPASS_MIX;
      default: table_entry = audio_pkg::CMD_READ_ID;
    endcase
  end

  // entries only load once the codec is out of reset
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      codec_command <= audio_pkg::CMD_READ_ID;
      command_loaded <= 1'b0;
      command_valid <= 1'b0;
    end else begin
      if (codec_reset_b) begin
        codec_command <= table_entry;
        command_loaded <= 1'b1;
      end
      if (command_loaded) begin
        command_valid <= 1'b1;
      end
    end
  end

  // frame ticks during the codec reset hold are not counted
  assert property (@(posedge clock_27mhz) disable iff (reset)
    !codec_reset_b |=> $stable(step));

endmodule

// File: capture/pingpong_capture.sv
`timescale 1ns/1ps

module pingpong_capture #(
  parameter int BLOCK_ADDR_BITS = 4
) (
  input  logic                   clock_27mhz,
  input  logic                   reset,
  input  logic                   frame_tick,
  input  audio_pkg::sample_t     sample_in,
  output logic                   block_valid,
  output audio_pkg::block_word_t block_word,
  input  logic                   block_ready,
  output logic                   overrun
);

  localparam int BLOCK_WORDS = 1 << BLOCK_ADDR_BITS;
  localparam logic [BLOCK_ADDR_BITS-1:0] LAST_ADDR = '1;

  // both banks, indexed by {bank, address}
  audio_pkg::sample_t mem [2*BLOCK_WORDS];

  logic [BLOCK_ADDR_BITS-1:0] fill_addr;
  logic fill_bank;
  logic [BLOCK_ADDR_BITS-1:0] read_addr;
  logic read_bank;
  // a full block is waiting or draining
  logic busy;
  logic fetch_pending;
  audio_pkg::sample_t mem_q;
  logic block_done;
  logic fill_done;

  assign read_bank = ~fill_bank;
  assign fill_done = frame_tick && (fill_addr == LAST_ADDR);
  assign block_done = block_valid && block_ready && block_word.last;

  ////////////////////////////////////////////////////////////
  // fill side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (frame_tick) begin
      mem[{fill_bank, fill_addr}] <= sample_in;
    end
    // read port always looks at the drain bank
    mem_q <= mem[{read_bank, read_addr}];
  end

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      fill_addr <= '0;
      fill_bank <= 1'b0;
      busy <= 1'b0;
      overrun <= 1'b0;
    end else begin
      if (frame_tick) begin
        fill_addr <= fill_addr + 1'b1;
      end
      if (fill_done && (!busy || block_done)) begin
        // hand the full bank to the reader
        fill_bank <= ~fill_bank;
        busy <= 1'b1;
      end else begin
        if (fill_done) begin
          // reader still busy, this block is dropped
          overrun <= 1'b1;
        end
        if (block_done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // drain side
  ////////////////////////////////////////////////////////////

  // one word in flight at a time
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      read_addr <= '0;
      fetch_pending <= 1'b0;
      block_valid <= 1'b0;
    end else begin
      if (fetch_pending) begin
        fetch_pending <= 1'b0;
        block_valid <= 1'b1;
        read_addr <= read_addr + 1'b1;
      end else if (block_valid) begin
        if (block_ready) begin
          block_valid <= 1'b0;
        end
      end else if (busy) begin
        fetch_pending <= 1'b1;
      end
    end
  end

  // mem_q now holds the word at read_addr
  always_ff @(posedge clock_27mhz) begin
    if (fetch_pending) begin
      block_word.last <= (read_addr == LAST_ADDR);
      block_word.sample <= mem_q;
    end
  end

  // word held until the consumer takes it
  assert property (@(posedge clock_27mhz) disable iff (reset)
    (block_valid && !block_ready) |=> (block_valid && $stable(block_word)));

endmodule

// File: verilog/audio_control_top.sv
`timescale 1ns/1ps

module audio_control_top #(
  parameter int DEBOUNCE_CYCLES = 270000,
  parameter int CODEC_RESET_CYCLES = 1024,
  parameter int BLOCK_ADDR_BITS = 4
) (
  input  logic                      clock_27mhz,
  input  logic                      reset,
  input  logic                      button_up,
  input  logic                      button_down,
  input  logic                      frame_tick,
  input  audio_pkg::sample_t        sample_in,
  input  logic                      block_ready,
  output audio_pkg::volume_t        volume,
  output logic                      codec_reset_b,
  output audio_pkg::codec_command_t codec_command,
  output logic                      command_valid,
  output logic                      block_valid,
  output audio_pkg::block_word_t    block_word,
  output logic                      overrun
);

  // volume also feeds the headphone command
  volume_control #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) volume_ctrl (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  codec_command_sequencer #(.CODEC_RESET_CYCLES(CODEC_RESET_CYCLES)) sequencer (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .frame_tick(frame_tick),
    .volume(volume),
    .codec_reset_b(codec_reset_b),
    .codec_command(codec_command),
    .command_valid(command_valid)
  );

  pingpong_capture #(.BLOCK_ADDR_BITS(BLOCK_ADDR_BITS)) capture (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .frame_tick(frame_tick),
    .sample_in(sample_in),
    .block_valid(block_valid),
    .block_word(block_word),
    .block_ready(block_ready),
    .overrun(overrun)
  );

endmodule

// File: testbench/tb_audio_control.sv
`timescale 1ns/1ps

module tb_audio_control;

  localparam int TIMEOUT_CYCLES = 6000;
  localparam int BLOCK_WORDS = 16;
  localparam int DRAIN_LIMIT = 200;

  logic clock_27mhz;
  logic reset;
  logic button_up;
  logic button_down;
  logic frame_tick;
  audio_pkg::sample_t sample_in;
  logic block_ready;
  audio_pkg::volume_t volume;
  logic codec_reset_b;
  audio_pkg::codec_command_t codec_command;
  logic command_valid;
  logic block_valid;
  audio_pkg::block_word_t block_word;
  logic overrun;

  logic [15:0] lfsr_state;
  int cycle_count = 0;
  audio_pkg::volume_t expected_volume;
  // samples the readout still owes in arrival order
  audio_pkg::sample_t expected_samples[$];

  audio_control_top #(
    .DEBOUNCE_CYCLES(8),
    .CODEC_RESET_CYCLES(20),
    .BLOCK_ADDR_BITS(4)
  ) uut (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .frame_tick(frame_tick),
    .sample_in(sample_in),
    .block_ready(block_ready),
    .volume(volume),
    .codec_reset_b(codec_reset_b),
    .codec_command(codec_command),
    .command_valid(command_valid),
    .block_valid(block_valid),
    .block_word(block_word),
    .overrun(overrun)
  );

  always #2 clock_27mhz = ~clock_27mhz;

  always @(posedge clock_27mhz) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
    $display("=== FAIL ===");
    $fatal(1, "%s check failed", name);
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "%s", what);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_bits(input int count, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[6:0], lfsr_state[0]};
    end
  endtask

  // inputs change 1 ns after the edge
  task automatic wait_cycles(input int count);
    repeat (count) @(posedge clock_27mhz);
    #1;
  endtask

  task automatic apply_reset;
    reset = 1'b1;
    wait_cycles(3);
    reset = 1'b0;
    expected_volume = audio_pkg::VOLUME_RESET;
    expected_samples.delete();
  endtask

  function automatic audio_pkg::volume_t stepped_volume(input audio_pkg::volume_t v,
                                                        input logic up);
    if (up) begin
      stepped_volume = (v == audio_pkg::VOLUME_MAX) ? v : v + 5'd1;
    end else begin
      stepped_volume = (v == 5'd0) ? v : v - 5'd1;
    end
  endfunction

  function automatic audio_pkg::codec_command_t expected_command(input logic [3:0] step,
                                                                 input audio_pkg::volume_t vol);
    audio_pkg::volume_t att;
    att = audio_pkg::VOLUME_MAX - vol;
    case (step)
      4'd3: expected_command = '{address: audio_pkg::REG_HEADPHONE_VOLUME,
                                 data: (16'(att) << 8) | 16'(att)};
      4'd5: expected_command = audio_pkg::CMD_PCM_VOLUME;
      4'd6: expected_command = audio_pkg::CMD_RECORD_SOURCE;
      4'd7: expected_command = audio_pkg::CMD_RECORD_GAIN;
      4'd9: expected_command = audio_pkg::CMD_MIC_GAIN;
      4'd10: expected_command = audio_pkg::CMD_BEEP_VOLUME;
      4'd11: expected_command = audio_pkg::CMD_BYPASS_MIX;
      default: expected_command = audio_pkg::CMD_READ_ID;
    endcase
  endfunction

  task automatic check_volume;
    assert (volume == expected_volume)
      else report_mismatch("volume", 32'(volume), 32'(expected_volume));
  endtask

  // press and let the release settle
  task automatic press_button(input logic up, input int hold_cycles);
    button_up = up;
    button_down = !up;
    wait_cycles(hold_cycles);
    button_up = 1'b0;
    button_down = 1'b0;
    wait_cycles(20);
  endtask

  task automatic send_samples(input int count, input int keep);
    logic [7:0] value;
    for (int i = 0; i < count; i++) begin
      random_bits(8, value);
      sample_in = value;
      frame_tick = 1'b1;
      if (i < keep) begin
        expected_samples.push_back(value);
      end
      wait_cycles(1);
      frame_tick = 1'b0;
      wait_cycles(2);
    end
  endtask

  task automatic drain_block(input logic use_stalls);
    logic [7:0] bits;
    logic ready_bit;
    audio_pkg::block_word_t expected_word;
    int received;
    int waited;
    received = 0;
    waited = 0;
    while (received < BLOCK_WORDS) begin
      if (use_stalls) begin
        random_bits(1, bits);
        ready_bit = bits[0];
      end else begin
        ready_bit = 1'b1;
      end
      block_ready = ready_bit;
      // word on the outputs now moves at the next edge
      if (block_valid && ready_bit) begin
        expected_word.sample = expected_samples.pop_front();
        expected_word.last = (received == BLOCK_WORDS - 1);
        assert (block_word == expected_word)
          else report_mismatch("block_word", 32'(block_word), 32'(expected_word));
        received++;
      end
      waited++;
      assert (waited <= DRAIN_LIMIT)
        else report_failure($sformatf("block readout stalled after %0d words", received));
      wait_cycles(1);
    end
    block_ready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_codec_reset_hold;
    logic exp_reset_b;
    logic exp_valid;
    apply_reset;
    for (int k = 1; k <= 22; k++) begin
      // three ticks inside the hold would land on the headphone step
      frame_tick = (k == 5) || (k == 9) || (k == 12);
      wait_cycles(1);
      frame_tick = 1'b0;
      exp_reset_b = (k >= 20);
      exp_valid = (k >= 22);
      assert (codec_reset_b == exp_reset_b)
        else report_mismatch("codec_reset_b", 32'(codec_reset_b), 32'(exp_reset_b));
      assert (command_valid == exp_valid)
        else report_mismatch("command_valid", 32'(command_valid), 32'(exp_valid));
    end
    assert (codec_command == expected_command(4'd0, expected_volume))
      else report_mismatch("codec_command", 32'(codec_command),
                           32'(expected_command(4'd0, expected_volume)));
  endtask

  task automatic test_volume_stepping;
    check_volume();
    press_button(1'b1, 20);
    expected_volume = stepped_volume(expected_volume, 1'b1);
    check_volume();
    // bounce shorter than the debounce time
    press_button(1'b1, 4);
    check_volume();
    press_button(1'b0, 20);
    expected_volume = stepped_volume(expected_volume, 1'b0);
    check_volume();
  endtask

  task automatic test_volume_saturation;
    repeat (25) begin
      press_button(1'b1, 20);
      expected_volume = stepped_volume(expected_volume, 1'b1);
      check_volume();
    end
    repeat (33) begin
      press_button(1'b0, 20);
      expected_volume = stepped_volume(expected_volume, 1'b0);
      check_volume();
    end
  endtask

  task automatic test_command_table;
    audio_pkg::codec_command_t expected;
    for (int n = 1; n <= 32; n++) begin
      frame_tick = 1'b1;
      wait_cycles(1);
      frame_tick = 1'b0;
      wait_cycles(2);
      expected = expected_command(4'(n % 16), expected_volume);
      assert (codec_command == expected)
        else report_mismatch("codec_command", 32'(codec_command), 32'(expected));
      assert (command_valid == 1'b1)
        else report_mismatch("command_valid", 32'(command_valid), 32'd1);
      wait_cycles(7);
    end
  endtask

  task automatic test_block_capture;
    apply_reset;
    assert (block_valid == 1'b0)
      else report_mismatch("block_valid", 32'(block_valid), 32'd0);
    assert (overrun == 1'b0)
      else report_mismatch("overrun", 32'(overrun), 32'd0);
    send_samples(BLOCK_WORDS, BLOCK_WORDS);
    drain_block(1'b1);
    block_ready = 1'b1;
    wait_cycles(8);
    block_ready = 1'b0;
    assert (block_valid == 1'b0)
      else report_mismatch("block_valid", 32'(block_valid), 32'd0);
    assert (overrun == 1'b0)
      else report_mismatch("overrun", 32'(overrun), 32'd0);
  endtask

  task automatic test_overrun;
    apply_reset;
    block_ready = 1'b0;
    // second block completes while the first is still unread
    send_samples(2 * BLOCK_WORDS, BLOCK_WORDS);
    assert (overrun == 1'b1)
      else report_mismatch("overrun", 32'(overrun), 32'd1);
    drain_block(1'b0);
    assert (overrun == 1'b1)
      else report_mismatch("overrun", 32'(overrun), 32'd1);
  endtask

  initial begin
    clock_27mhz = 1'b0;
    reset = 1'b1;
    button_up = 1'b0;
    button_down = 1'b0;
    frame_tick = 1'b0;
    sample_in = '0;
    block_ready = 1'b0;
    lfsr_state = 16'd87;
    test_codec_reset_hold();
    test_volume_stepping();
    test_volume_saturation();
    test_command_table();
    test_block_capture();
    test_overrun();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: src.f
common/audio_pkg.sv
verilog/key_debounce.sv
verilog/volume_control.sv
codec/codec_command_sequencer.sv
capture/pingpong_capture.sv
verilog/audio_control_top.sv
testbench/tb_audio_control.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_audio_control \
  -f src.f \
  -o tb_audio_control

./obj_dir/tb_audio_control
